/* rd_id_remap.f */
src/axi_rd_pkg.sv
src/remap_pkg.sv
src/id_remap_table.sv
src/ar_remap_ctrl.sv
src/rd_id_remap_top.sv
testbench/tb_rd_id_remap.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the read ID remapper testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f rd_id_remap.f \
  --top-module tb_rd_id_remap \
  -o sim_rd_id_remap

output=$(./obj_dir/sim_rd_id_remap)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
else
  exit 1
fi

/* src/ar_remap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// AR admission control
// Decides whether an incoming AR may enter the table, picks its index and builds
// the master-side ID from the class prefix and that index
module ar_remap_ctrl
  import axi_rd_pkg::*;
  import remap_pkg::*;
#(
  parameter int unsigned NumEntries   = 4,
  parameter int unsigned MaxTxnsPerId = 2
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Slave side AR
  input  slv_ar_t slv_ar_i,
  input  logic    slv_ar_valid_i,
  output logic    slv_ar_ready_o,
  // Master side AR
  output mst_ar_t mst_ar_o,
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  // Table lookups for the current AR ID
  input  logic    exists_i,
  input  idx_t    exists_idx_i,
  input  logic    exists_full_i,
  input  logic    full_i,
  input  idx_t    free_idx_i,
  // Table allocation
  output logic    push_o,
  output idx_t    push_idx_o
);

  ar_state_e state_q;
  ar_state_e state_d;
  // Index of a request that waits for the master to accept it
  idx_t      hold_idx_q;
  idx_t      hold_idx_d;
  logic      admit;
  idx_t      mst_idx;
  prefix_t   prefix;

  // ******************************
  // Admission
  // ******************************

  // A known ID may add to its entry until the limit, a new ID needs a free entry
  assign admit = slv_ar_valid_i && (exists_i ? !exists_full_i : !full_i);

  // Reuse keeps bursts with one input ID on one master ID, so their order holds
  assign push_idx_o = exists_i ? exists_idx_i : free_idx_i;

  always_comb begin
    state_d        = state_q;
    hold_idx_d     = hold_idx_q;
    mst_ar_valid_o = 1'b0;
    slv_ar_ready_o = 1'b0;
    push_o         = 1'b0;
    mst_idx        = push_idx_o;
    case (state_q)
      Ready: begin
        // The table is updated now even if the master stalls the AR
        if (admit) begin
          mst_ar_valid_o = 1'b1;
          slv_ar_ready_o = mst_ar_ready_i;
          push_o         = 1'b1;
          if (!mst_ar_ready_i) begin
            state_d    = Hold;
            hold_idx_d = push_idx_o;
          end
        end
      end
      Hold: begin
        // Already counted, so keep presenting it without a second push
        mst_idx        = hold_idx_q;
        mst_ar_valid_o = 1'b1;
        slv_ar_ready_o = mst_ar_ready_i;
        if (mst_ar_ready_i) begin
          state_d = Ready;
        end
      end
      default: begin
        state_d = Ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= Ready;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    hold_idx_q <= hold_idx_d;
  end

  // ******************************
  // Master ID composition
  // ******************************

  // Coherent traffic is sorted by core, the other classes keep their code
  // Code 11 is not expected and falls back to core 0
  always_comb begin
    case (slv_ar_i.id[ClassMsb:ClassLsb])
      PrefixCoherent: prefix = slv_ar_i.id[CoreSelBit] ? PrefixCore1 : PrefixCore0;
      PrefixCore0:    prefix = PrefixCore0;
      PrefixCore1:    prefix = PrefixCore1;
      default:        prefix = PrefixCore0;
    endcase
  end

  assign mst_ar_o = '{id: {prefix, mst_idx}, addr: slv_ar_i.addr, len: slv_ar_i.len};

  // ******************************
  // Assertions
  // ******************************

  initial begin
    assert ((NumEntries >= 1) && (NumEntries <= (1 << IdxWidth)))
      else $error("NumEntries out of range");
    assert ((MaxTxnsPerId >= 1) && (MaxTxnsPerId < (1 << CntWidth)))
      else $error("MaxTxnsPerId out of range");
  end

  // A stalled AR stays on the bus with the same ID until the master takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o.id))
    else $error("Held AR changed before transfer");

endmodule

`default_nettype wire

/* src/axi_rd_pkg.sv */
`default_nettype none

// AXI read-channel widths and channel structs on both sides of the remapper
package axi_rd_pkg;

  // Upstream IDs are wide and sparse, downstream IDs are dense
  localparam int unsigned SlvIdWidth = 7;
  localparam int unsigned MstIdWidth = 4;
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned LenWidth   = 8;
  localparam int unsigned DataWidth  = 32;

  typedef logic [SlvIdWidth-1:0] slv_id_t;
  typedef logic [MstIdWidth-1:0] mst_id_t;
  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [LenWidth-1:0]   len_t;
  typedef logic [DataWidth-1:0]  data_t;

  // AR payload as seen on the slave port
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ar_t;

  // AR payload after remapping, only the ID is narrower
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ar_t;

  // R beat as returned to the slave port
  typedef struct packed {
    slv_id_t id;
    data_t   data;
    logic    last;
  } slv_r_t;

  // R beat as delivered by the downstream slave
  typedef struct packed {
    mst_id_t id;
    data_t   data;
    logic    last;
  } mst_r_t;

endpackage

`default_nettype wire

/* src/id_remap_table.sv */
`timescale 1ns/1ps
`default_nettype none

// Remap table indexed by the output index
// Every entry keeps the input ID it serves and how many transactions are in flight for it
module id_remap_table
  import axi_rd_pkg::*;
  import remap_pkg::*;
#(
  parameter int unsigned NumEntries   = 4,
  parameter int unsigned MaxTxnsPerId = 2
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Lookup of the incoming AR ID
  input  slv_id_t lookup_id_i,
  output logic    exists_o,
  output idx_t    exists_idx_o,
  output logic    exists_full_o,
  // Free entry search
  output logic    full_o,
  output idx_t    free_idx_o,
  // Allocation on an admitted AR
  input  logic    push_i,
  input  slv_id_t push_id_i,
  input  idx_t    push_idx_i,
  // Release on the last R beat
  input  logic    pop_i,
  input  idx_t    pop_idx_i,
  output slv_id_t pop_id_o
);

  // Count value at which an ID accepts no further transaction
  localparam cnt_t CntMax = cnt_t'(MaxTxnsPerId);

  // ******************************
  // Storage
  // ******************************

  // Input ID per entry, only meaningful while the count is nonzero
  slv_id_t id_q [NumEntries];
  // In-flight count per entry
  cnt_t    cnt_q [NumEntries];
  cnt_t    cnt_d [NumEntries];

  // One bit per entry
  logic [NumEntries-1:0] free;
  logic [NumEntries-1:0] match;

  // ******************************
  // Lookups
  // ******************************

  // An entry is free once its count has dropped to zero
  // A match needs a live entry, so stale IDs in free entries never hit
  always_comb begin
    for (int i = 0; i < NumEntries; i++) begin
      free[i]  = (cnt_q[i] == '0);
      match[i] = (cnt_q[i] != '0) && (id_q[i] == lookup_id_i);
    end
  end

  // Lowest free entry wins
  // The loop runs downwards so that the last hit is the lowest index
  always_comb begin
    free_idx_o = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (free[i]) begin
        free_idx_o = idx_t'(i);
      end
    end
  end

  // At most one entry can match, the priority search only picks its index
  always_comb begin
    exists_idx_o = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (match[i]) begin
        exists_idx_o = idx_t'(i);
      end
    end
  end

  assign full_o        = ~|free;
  assign exists_o      = |match;
  assign exists_full_o = (cnt_q[exists_idx_o] == CntMax);

  // Input ID handed back for the R beat that is leaving
  assign pop_id_o = id_q[pop_idx_i];

  // ******************************
  // Push and pop
  // ******************************

  // A push and a pop on the same entry in one cycle cancel out
  always_comb begin
    for (int i = 0; i < NumEntries; i++) begin
      cnt_d[i] = cnt_q[i];
      if (push_i && (push_idx_i == idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] + cnt_t'(1);
      end
      if (pop_i && (pop_idx_i == idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NumEntries; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumEntries; i++) begin
        cnt_q[i] <= cnt_d[i];
      end
    end
  end

  // Rewriting the ID of a live entry stores the same value again
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[push_idx_i] <= push_id_i;
    end
  end

  // ******************************
  // Assertions
  // ******************************

  // The control module only pushes below the per-ID limit, onto a free entry
  // or onto the one that already holds this ID
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> (cnt_q[push_idx_i] < CntMax) &&
               ((cnt_q[push_idx_i] == '0) || (id_q[push_idx_i] == push_id_i)))
    else $error("Push overfills entry %0d", push_idx_i);

  // Every last beat must belong to an outstanding burst
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> (cnt_q[pop_idx_i] != '0))
    else $error("Pop underflows entry %0d", pop_idx_i);

  // Index reuse keeps each input ID in one entry only
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(match))
    else $error("Input ID held by more than one entry");

endmodule

`default_nettype wire

/* src/rd_id_remap_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Read-channel ID remapper
// AR IDs are compressed through the remap table, R beats get their original ID back
module rd_id_remap_top
  import axi_rd_pkg::*;
  import remap_pkg::*;
#(
  parameter int unsigned NumEntries   = 4,
  parameter int unsigned MaxTxnsPerId = 2
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Slave port
  input  slv_ar_t slv_ar_i,
  input  logic    slv_ar_valid_i,
  output logic    slv_ar_ready_o,
  output slv_r_t  slv_r_o,
  output logic    slv_r_valid_o,
  input  logic    slv_r_ready_i,
  // Master port
  output mst_ar_t mst_ar_o,
  output logic    mst_ar_valid_o,
  input  logic    mst_ar_ready_i,
  input  mst_r_t  mst_r_i,
  input  logic    mst_r_valid_i,
  output logic    mst_r_ready_o
);

  logic    exists;
  idx_t    exists_idx;
  logic    exists_full;
  logic    full;
  idx_t    free_idx;
  logic    push;
  idx_t    push_idx;
  logic    pop;
  idx_t    pop_idx;
  slv_id_t pop_id;

  // ******************************
  // R return path
  // ******************************

  // The low bits of the master ID are the table index, the prefix is dropped
  assign pop_idx = mst_r_i.id[IdxWidth-1:0];

  // An entry is released by the beat that ends its burst
  assign pop = mst_r_valid_i && slv_r_ready_i && mst_r_i.last;

  assign slv_r_o       = '{id: pop_id, data: mst_r_i.data, last: mst_r_i.last};
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;

  id_remap_table #(
    .NumEntries   (NumEntries),
    .MaxTxnsPerId (MaxTxnsPerId)
  ) u_table (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .lookup_id_i   (slv_ar_i.id),
    .exists_o      (exists),
    .exists_idx_o  (exists_idx),
    .exists_full_o (exists_full),
    .full_o        (full),
    .free_idx_o    (free_idx),
    .push_i        (push),
    .push_id_i     (slv_ar_i.id),
    .push_idx_i    (push_idx),
    .pop_i         (pop),
    .pop_idx_i     (pop_idx),
    .pop_id_o      (pop_id)
  );

  ar_remap_ctrl #(
    .NumEntries   (NumEntries),
    .MaxTxnsPerId (MaxTxnsPerId)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .slv_ar_i       (slv_ar_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .exists_i       (exists),
    .exists_idx_i   (exists_idx),
    .exists_full_i  (exists_full),
    .full_i         (full),
    .free_idx_i     (free_idx),
    .push_o         (push),
    .push_idx_o     (push_idx)
  );

endmodule

`default_nettype wire

/* src/remap_pkg.sv */
`default_nettype none

// Types and constants specific to the ID remapping logic
package remap_pkg;

  // Table index width, four entries at most
  localparam int unsigned IdxWidth    = 2;
  // In-flight counter width, seven transactions per ID at most
  localparam int unsigned CntWidth    = 3;
  localparam int unsigned PrefixWidth = 2;

  typedef logic [IdxWidth-1:0]    idx_t;
  typedef logic [CntWidth-1:0]    cnt_t;
  typedef logic [PrefixWidth-1:0] prefix_t;

  // Class field position inside the incoming ID
  localparam int unsigned ClassMsb   = 6;
  localparam int unsigned ClassLsb   = 5;
  // Selects the core for coherent traffic
  localparam int unsigned CoreSelBit = 4;

  // Codes of the class field, which double as prefixes
  localparam prefix_t PrefixCore0    = 2'b00;
  localparam prefix_t PrefixCore1    = 2'b01;
  localparam prefix_t PrefixCoherent = 2'b10;

  // AR admission FSM
  typedef enum logic {
    Ready,
    Hold
  } ar_state_e;

endpackage

`default_nettype wire

/* testbench/tb_rd_id_remap.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rd_id_remap
  import axi_rd_pkg::*;
  import remap_pkg::*;
();

  localparam int unsigned NumEntries   = 4;
  localparam int unsigned MaxTxnsPerId = 2;
  localparam int          Period       = 100;

  // One outstanding AR as the downstream slave sees it together with the ID it came with
  typedef struct packed {
    mst_id_t mid;
    slv_id_t sid;
  } pend_t;

  logic    clk_i;
  logic    rst_n_i;
  slv_ar_t slv_ar_i;
  logic    slv_ar_valid_i;
  logic    slv_ar_ready_o;
  slv_r_t  slv_r_o;
  logic    slv_r_valid_o;
  logic    slv_r_ready_i;
  mst_ar_t mst_ar_o;
  logic    mst_ar_valid_o;
  logic    mst_ar_ready_i;
  mst_r_t  mst_r_i;
  logic    mst_r_valid_i;
  logic    mst_r_ready_o;

  integer  seed;
  int      errors;
  int      checks;
  int      tests_run;
  int      tests_failed;
  int      test_start_errors;
  // ARs accepted downstream and not yet answered
  pend_t   pend_q [$];
  // Input ID that the R beat on the bus must carry back
  slv_id_t r_exp_id;
  // Table model that keeps the input ID and the number of open bursts per index
  slv_id_t model_id [NumEntries];
  int      model_cnt [NumEntries];
  logic    held;
  idx_t    held_idx;

  rd_id_remap_top #(
    .NumEntries   (NumEntries),
    .MaxTxnsPerId (MaxTxnsPerId)
  ) DUT (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .slv_ar_i       (slv_ar_i),
    .slv_ar_valid_i (slv_ar_valid_i),
    .slv_ar_ready_o (slv_ar_ready_o),
    .slv_r_o        (slv_r_o),
    .slv_r_valid_o  (slv_r_valid_o),
    .slv_r_ready_i  (slv_r_ready_i),
    .mst_ar_o       (mst_ar_o),
    .mst_ar_valid_o (mst_ar_valid_o),
    .mst_ar_ready_i (mst_ar_ready_i),
    .mst_r_i        (mst_r_i),
    .mst_r_valid_i  (mst_r_valid_i),
    .mst_r_ready_o  (mst_r_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(Period/2) clk_i = ~clk_i;
  end

  // Hard limit on the whole run
  initial begin
    repeat (20000) @(posedge clk_i);
    $display("Timeout: the simulation ran past its cycle limit");
    $display("TEST FAILED");
    $finish;
  end

  // ******************************
  // Reference and reporting
  // ******************************

  // Coherent traffic splits by the core bit, code 11 falls back to core 0
  function automatic prefix_t expected_prefix(input slv_id_t id);
    if (id[6:5] == 2'b10) begin
      return {1'b0, id[4]};
    end
    if (id[6:5] == 2'b11) begin
      return 2'b00;
    end
    return id[6:5];
  endfunction

  function automatic mst_id_t expected_mst_id(input slv_id_t id, input idx_t idx);
    return {expected_prefix(id), idx};
  endfunction

  // An open ID keeps its index below the limit, a new ID takes the lowest free index
  task automatic model_lookup(input slv_id_t id, output logic ok, output idx_t idx);
    logic hit;
    hit = 1'b0;
    ok  = 1'b0;
    idx = '0;
    for (int i = 0; i < NumEntries; i++) begin
      if (!hit && (model_cnt[i] != 0) && (model_id[i] == id)) begin
        hit = 1'b1;
        idx = idx_t'(i);
        ok  = (model_cnt[i] < MaxTxnsPerId);
      end
    end
    for (int i = 0; i < NumEntries; i++) begin
      if (!hit && !ok && (model_cnt[i] == 0)) begin
        ok  = 1'b1;
        idx = idx_t'(i);
      end
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("Error: time %0t ns, %s expected %0h, got %0h", $time, name, exp, got);
        errors++;
      end
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond)
      else report_failure(msg);
  endtask

  task automatic start_test();
    test_start_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name,
               errors - test_start_errors);
    end
  endtask

  // ******************************
  // Checker
  // ******************************

  // Samples a quarter period after the falling edge, so the values seen here are
  // the ones the next rising edge acts on
  always @(negedge clk_i) begin : compare
    logic exp_valid;
    idx_t exp_idx;
    idx_t pidx;
    #(Period/4);
    if (!rst_n_i) begin
      for (int i = 0; i < NumEntries; i++) begin
        model_cnt[i] = 0;
      end
      held = 1'b0;
    end else begin
      exp_valid = 1'b0;
      exp_idx   = '0;
      if (held) begin
        exp_valid = 1'b1;
        exp_idx   = held_idx;
      end else if (slv_ar_valid_i) begin
        model_lookup(slv_ar_i.id, exp_valid, exp_idx);
      end
      check_value("mst_ar_valid_o", 64'(mst_ar_valid_o), 64'(exp_valid));
      if (exp_valid) begin
        check_value("mst_ar_o.id", 64'(mst_ar_o.id), 64'(expected_mst_id(slv_ar_i.id, exp_idx)));
        check_value("mst_ar_o.addr", 64'(mst_ar_o.addr), 64'(slv_ar_i.addr));
        check_value("mst_ar_o.len", 64'(mst_ar_o.len), 64'(slv_ar_i.len));
        check_value("slv_ar_ready_o", 64'(slv_ar_ready_o), 64'(mst_ar_ready_i));
        // The table counts the burst on its first cycle, not when it is taken
        if (!held) begin
          model_id[exp_idx]  = slv_ar_i.id;
          model_cnt[exp_idx] = model_cnt[exp_idx] + 1;
        end
        held_idx = exp_idx;
        held     = !mst_ar_ready_i;
        if (mst_ar_ready_i) begin
          pend_q.push_back('{mid: mst_ar_o.id, sid: slv_ar_i.id});
        end
      end else begin
        check_value("slv_ar_ready_o", 64'(slv_ar_ready_o), 64'(0));
      end

      // R handling comes after AR, a pop only shows up at the next edge
      if (mst_r_valid_i) begin
        check_value("slv_r_valid_o", 64'(slv_r_valid_o), 64'(1));
        check_value("mst_r_ready_o", 64'(mst_r_ready_o), 64'(slv_r_ready_i));
        check_value("slv_r_o.id", 64'(slv_r_o.id), 64'(r_exp_id));
        check_value("slv_r_o.data", 64'(slv_r_o.data), 64'(mst_r_i.data));
        check_value("slv_r_o.last", 64'(slv_r_o.last), 64'(mst_r_i.last));
        if (slv_r_ready_i && mst_r_i.last) begin
          pidx = mst_r_i.id[IdxWidth-1:0];
          if (model_cnt[pidx] == 0) begin
            report_failure("R beat returned for an index with nothing in flight");
          end else begin
            model_cnt[pidx] = model_cnt[pidx] - 1;
          end
        end
      end else begin
        check_value("slv_r_valid_o", 64'(slv_r_valid_o), 64'(0));
      end
    end
  end

  // ******************************
  // Stimulus tasks
  // ******************************

  // Any AR still on the slave port is withdrawn while the reset is applied
  task automatic apply_reset();
    @(negedge clk_i);
    rst_n_i        = 1'b0;
    slv_ar_valid_i = 1'b0;
    mst_ar_ready_i = 1'b1;
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
  endtask

  task automatic present_ar(input slv_id_t id);
    @(negedge clk_i);
    slv_ar_i.id    = id;
    slv_ar_i.addr  = addr_t'($random(seed));
    slv_ar_i.len   = len_t'($random(seed));
    slv_ar_valid_i = 1'b1;
  endtask

  // Holds the AR on the bus until the DUT takes it
  task automatic wait_ar_accept(input int max_cycles);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && (cycles < max_cycles)) begin
      #(Period/4);
      if (slv_ar_ready_o) begin
        done = 1'b1;
      end else begin
        @(negedge clk_i);
        cycles++;
      end
    end
    if (!done) begin
      report_failure("AR was not accepted before the timeout");
    end
    @(negedge clk_i);
    slv_ar_valid_i = 1'b0;
  endtask

  task automatic send_ar(input slv_id_t id);
    present_ar(id);
    wait_ar_accept(20);
  endtask

  // Answers one outstanding AR with a single-beat burst
  // A random pick is moved to the oldest AR of the same master ID, so order per ID holds
  task automatic return_r(input logic pick_random);
    pend_t sel;
    int    k;
    int    j;
    int    cycles;
    logic  done;
    if (pend_q.size() == 0) begin
      report_failure("No outstanding AR to answer");
      return;
    end
    k = 0;
    if (pick_random) begin
      k = int'($unsigned($random(seed)) % pend_q.size());
    end
    j = k;
    for (int i = k - 1; i >= 0; i--) begin
      if (pend_q[i].mid == pend_q[k].mid) begin
        j = i;
      end
    end
    sel = pend_q[j];
    pend_q.delete(j);
    @(negedge clk_i);
    r_exp_id      = sel.sid;
    mst_r_i.id    = sel.mid;
    mst_r_i.data  = data_t'($random(seed));
    mst_r_i.last  = 1'b1;
    mst_r_valid_i = 1'b1;
    slv_r_ready_i = 1'($random(seed));
    cycles = 0;
    done   = 1'b0;
    while (!done && (cycles < 20)) begin
      #(Period/4);
      if (mst_r_ready_o) begin
        done = 1'b1;
      end else begin
        @(negedge clk_i);
        slv_r_ready_i = 1'b1;
        cycles++;
      end
    end
    if (!done) begin
      report_failure("R beat was not taken before the timeout");
    end
    @(negedge clk_i);
    mst_r_valid_i = 1'b0;
    slv_r_ready_i = 1'b0;
  endtask

  task automatic drain();
    while (pend_q.size() != 0) begin
      return_r(1'b1);
    end
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin : stimulus
    slv_id_t id;
    slv_id_t ids [5];
    mst_ar_t held_ar;
    int      hold_cycles;
    logic    ok;
    idx_t    idx;
    logic [4:0] base;

    seed           = 32'hd126_9ab3;
    errors         = 0;
    checks         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    r_exp_id       = '0;
    held           = 1'b0;
    held_idx       = '0;
    rst_n_i        = 1'b0;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    mst_ar_ready_i = 1'b1;
    mst_r_i        = '0;
    mst_r_valid_i  = 1'b0;
    slv_r_ready_i  = 1'b0;
    apply_reset();

    // Three random IDs of every class are each answered before the next
    start_test();
    for (int c = 0; c < 4; c++) begin
      for (int n = 0; n < 3; n++) begin
        id = {2'(c), 5'($random(seed))};
        send_ar(id);
        check_value("mst_ar_o.id prefix", 64'(pend_q[$].mid[3:2]), 64'(expected_prefix(id)));
        return_r(1'b0);
      end
    end
    end_test("prefix");

    start_test();
    ids[0] = slv_id_t'($random(seed));
    ids[1] = ids[0] ^ 7'h01;
    send_ar(ids[0]);
    send_ar(ids[0]);
    send_ar(ids[1]);
    check_true(pend_q.size() == 3, "Three ARs were expected downstream");
    check_value("index of repeated ID", 64'(pend_q[1].mid[1:0]), 64'(pend_q[0].mid[1:0]));
    check_true(pend_q[2].mid[1:0] != pend_q[0].mid[1:0], "Two open input IDs share one index");
    drain();
    end_test("index reuse");

    // Five IDs share four entries and the answers come in random order
    start_test();
    for (int i = 0; i < 5; i++) begin
      ids[i] = slv_id_t'($random(seed));
    end
    for (int n = 0; n < 16; n++) begin
      id = ids[$unsigned($random(seed)) % 5];
      model_lookup(id, ok, idx);
      while (!ok && (pend_q.size() != 0)) begin
        return_r(1'b1);
        model_lookup(id, ok, idx);
      end
      send_ar(id);
    end
    drain();
    end_test("id restore");

    start_test();
    id = slv_id_t'($random(seed));
    send_ar(id);
    send_ar(id);
    present_ar(id);
    #(Period/4);
    check_value("mst_ar_valid_o", 64'(mst_ar_valid_o), 64'(0));
    check_value("slv_ar_ready_o", 64'(slv_ar_ready_o), 64'(0));
    repeat (3) @(negedge clk_i);
    return_r(1'b0);
    wait_ar_accept(20);
    drain();
    base = 5'($random(seed));
    for (int i = 0; i < 4; i++) begin
      send_ar({2'(i), base});
    end
    present_ar({2'b00, base ^ 5'h01});
    #(Period/4);
    check_value("mst_ar_valid_o", 64'(mst_ar_valid_o), 64'(0));
    repeat (3) @(negedge clk_i);
    // The oldest burst sits in index 0, which the waiting ID then takes
    return_r(1'b0);
    wait_ar_accept(20);
    check_value("index after release", 64'(pend_q[$].mid[1:0]), 64'(0));
    drain();
    end_test("stall");

    // Every cycle after the first one runs in the Hold state
    start_test();
    for (int n = 0; n < 3; n++) begin
      id          = slv_id_t'($random(seed));
      hold_cycles = 1 + int'($unsigned($random(seed)) % 6);
      mst_ar_ready_i = 1'b0;
      present_ar(id);
      #(Period/4);
      held_ar = mst_ar_o;
      repeat (hold_cycles) begin
        @(negedge clk_i);
        #(Period/4);
        check_value("mst_ar_valid_o", 64'(mst_ar_valid_o), 64'(1));
        check_value("slv_ar_ready_o", 64'(slv_ar_ready_o), 64'(0));
        check_value("mst_ar_o", 64'(mst_ar_o), 64'(held_ar));
      end
      @(negedge clk_i);
      mst_ar_ready_i = 1'b1;
      wait_ar_accept(20);
      return_r(1'b0);
    end
    end_test("back-pressure");

    // The reset hits two open bursts and a third AR waiting in Hold
    // Afterwards the FSM is back in Ready and every index is free again
    start_test();
    id = slv_id_t'($random(seed));
    send_ar(id);
    send_ar(slv_id_t'($random(seed)));
    mst_ar_ready_i = 1'b0;
    present_ar(id ^ 7'h01);
    apply_reset();
    pend_q.delete();
    #(Period/4);
    check_value("mst_ar_valid_o", 64'(mst_ar_valid_o), 64'(0));
    check_value("slv_ar_ready_o", 64'(slv_ar_ready_o), 64'(0));
    base = 5'($random(seed));
    for (int i = 0; i < 4; i++) begin
      send_ar({2'(i), base});
      check_value("index after reset", 64'(pend_q[i].mid[1:0]), 64'(i));
    end
    drain();
    end_test("reset");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
